// ==== core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ========================================
// core-wide sizing
// ========================================

// data path and address width
`define XLEN 32

// general purpose registers, x0 included
`define REG_COUNT 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    // ========================================
    // instruction encodings
    // ========================================

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ========================================
    // control encodings
    // ========================================

    // alu function select
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLT = 3'b101
    } alu_op_e;

    // immediate layout
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_sel_e;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10,
        RES_IMM = 2'b11
    } result_sel_e;

    // flags of the alu adder, consumed by branch decode
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_t;

endpackage

`default_nettype wire

// ==== ctrl_if.sv ====
`default_nettype none

interface ctrl_if import core_pkg::*; ();

    // decoded control, all levels, valid for the current instruction
    alu_op_e     alu_op;
    // operand b from immediate
    logic        alu_src;
    imm_sel_e    imm_sel;
    result_sel_e result_sel;
    logic        reg_write;
    logic        mem_write;
    // next pc from branch/jump target
    logic        pc_src;

    // driven by the decoder only
    modport decoder (
        output alu_op, alu_src, imm_sel, result_sel, reg_write, mem_write, pc_src
    );

    // consumers in the datapath
    modport datapath (
        input alu_op, alu_src, imm_sel, result_sel, reg_write, mem_write, pc_src
    );

endinterface

`default_nettype wire

// ==== control_decoder.sv ====
`default_nettype none
`include "core_settings.svh"

module control_decoder import core_pkg::*; (
    input  wire logic [`XLEN-1:0] instr_i,
    input  wire alu_flags_t       flags_i,
    ctrl_if.decoder               ctrl
);

    // instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    // funct3 maps to one of the kept alu ops
    logic       fn_ok;
    alu_op_e    fn_op;
    // branch condition from flags
    logic       br_take;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    // ========================================
    // alu function from funct3
    // ========================================
    always_comb begin
        fn_ok = 1'b1;
        case (funct3)
            3'b000:  fn_op = ALU_ADD;
            3'b010:  fn_op = ALU_SLT;
            3'b100:  fn_op = ALU_XOR;
            3'b110:  fn_op = ALU_OR;
            3'b111:  fn_op = ALU_AND;
            default: begin
                // shifts, sltu not supported
                fn_op = ALU_ADD;
                fn_ok = 1'b0;
            end
        endcase
    end

    // ========================================
    // main decode
    // ========================================
    always_comb begin
        // safe defaults, nothing written
        ctrl.alu_op     = ALU_ADD;
        ctrl.alu_src    = 1'b0;
        ctrl.imm_sel    = IMM_I;
        ctrl.result_sel = RES_ALU;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_write  = 1'b0;
        case (opcode)
            OPC_OP: begin
                // sub only on the add slot
                ctrl.alu_op    = (funct3 == 3'b000 && funct7_b5) ? ALU_SUB : fn_op;
                ctrl.reg_write = fn_ok;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = fn_op;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = fn_ok;
            end
            OPC_LOAD: begin
                // word loads only
                ctrl.alu_src    = 1'b1;
                ctrl.result_sel = RES_MEM;
                ctrl.reg_write  = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.imm_sel   = IMM_S;
                ctrl.mem_write = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                // compare by subtraction, rs1 - rs2
                ctrl.alu_op  = ALU_SUB;
                ctrl.imm_sel = IMM_B;
            end
            OPC_JAL: begin
                ctrl.imm_sel    = IMM_J;
                ctrl.result_sel = RES_PC4;
                ctrl.reg_write  = 1'b1;
            end
            OPC_LUI: begin
                ctrl.imm_sel    = IMM_U;
                ctrl.result_sel = RES_IMM;
                ctrl.reg_write  = 1'b1;
            end
            default: ;
        endcase
    end

    // ========================================
    // next pc select
    // ========================================
    // kept apart from main decode, flags come back from the alu
    always_comb begin
        case (funct3)
            3'b000:  br_take = flags_i.zero;
            3'b001:  br_take = !flags_i.zero;
            3'b100:  br_take = flags_i.negative ^ flags_i.overflow;
            default: br_take = 1'b0;
        endcase
        ctrl.pc_src = (opcode == OPC_JAL) || ((opcode == OPC_BRANCH) && br_take);
    end

    // a store never writes back
    always_comb begin
        a_no_store_wb: assert final (!(ctrl.mem_write && ctrl.reg_write));
    end

endmodule

`default_nettype wire

// ==== imm_extend.sv ====
`default_nettype none
`include "core_settings.svh"

module imm_extend import core_pkg::*; (
    input  wire logic [`XLEN-1:0] instr_i,
    ctrl_if.datapath              ctrl,
    output logic [`XLEN-1:0]      imm_o
);

    // sign bit is always instr[31]
    logic sgn;

    assign sgn = instr_i[31];

    // ========================================
    // immediate formats
    // ========================================
    always_comb begin
        case (ctrl.imm_sel)
            IMM_I: begin
                // addi, lw
                imm_o = {{(`XLEN-12){sgn}}, instr_i[31:20]};
            end
            IMM_S: begin
                // split field, sw
                imm_o = {{(`XLEN-12){sgn}}, instr_i[31:25], instr_i[11:7]};
            end
            IMM_B: begin
                // halfword offset, bit 0 implied
                imm_o = {{(`XLEN-12){sgn}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            IMM_J: begin
                // jal offset, 21 bits
                imm_o = {{(`XLEN-20){sgn}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            IMM_U: begin
                // upper 20, low 12 zero
                imm_o = {instr_i[31:12], 12'h000};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none
`include "core_settings.svh"

module alu import core_pkg::*; (
    input  wire logic [`XLEN-1:0] a_i,
    input  wire logic [`XLEN-1:0] b_i,
    input  wire alu_op_e          op_i,
    output logic [`XLEN-1:0]      result_o,
    output alu_flags_t            flags_o
);

    // subtract as a + ~b + 1
    logic             do_sub;
    logic [`XLEN-1:0] b_eff;
    logic [`XLEN-1:0] sum;
    logic             carry;
    logic             ovf;

    // ========================================
    // shared add/subtract path
    // ========================================
    assign do_sub = (op_i == ALU_SUB) || (op_i == ALU_SLT);
    assign b_eff  = do_sub ? ~b_i : b_i;

    assign {carry, sum} = {1'b0, a_i} + {1'b0, b_eff} + {{`XLEN{1'b0}}, do_sub};

    // signs of operands agree, sign of sum flips
    assign ovf = (a_i[`XLEN-1] == b_eff[`XLEN-1]) && (sum[`XLEN-1] != a_i[`XLEN-1]);

    // ========================================
    // result select
    // ========================================
    always_comb begin
        case (op_i)
            ALU_ADD, ALU_SUB: result_o = sum;
            ALU_AND:          result_o = a_i & b_i;
            ALU_OR:           result_o = a_i | b_i;
            ALU_XOR:          result_o = a_i ^ b_i;
            // signed less-than, 0 or 1
            ALU_SLT:          result_o = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ ovf};
            default:          result_o = sum;
        endcase
    end

    // flags follow the adder, zero the result
    assign flags_o.zero     = (result_o == '0);
    assign flags_o.negative = sum[`XLEN-1];
    assign flags_o.carry    = carry;
    assign flags_o.overflow = ovf;

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none
`include "core_settings.svh"

module register_file (
    input  wire logic             clk,
    input  wire logic             arst_n_i,
    input  wire logic [4:0]       rs1_addr_i,
    input  wire logic [4:0]       rs2_addr_i,
    input  wire logic [4:0]       rd_addr_i,
    input  wire logic             rd_we_i,
    input  wire logic [`XLEN-1:0] rd_data_i,
    output logic [`XLEN-1:0]      rs1_data_o,
    output logic [`XLEN-1:0]      rs2_data_o
);

    // x0 entry kept, never written
    logic [`XLEN-1:0] regs [`REG_COUNT];

    // ========================================
    // write port
    // ========================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && (rd_addr_i != 5'd0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // read ports, no bypass
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // x0 stays zero whatever was written before
    a_x0_rs1: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rs1_addr_i == 5'd0) |-> (rs1_data_o == '0));
    a_x0_rs2: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rs2_addr_i == 5'd0) |-> (rs2_data_o == '0));

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`default_nettype none
`include "core_settings.svh"

module pc_unit (
    input  wire logic             clk,
    input  wire logic             arst_n_i,
    input  wire logic [`XLEN-1:0] imm_i,
    ctrl_if.datapath              ctrl,
    output logic [`XLEN-1:0]      pc_o,
    output logic [`XLEN-1:0]      pc_plus4_o
);

    // branch or jal destination
    logic [`XLEN-1:0] pc_target;
    logic [`XLEN-1:0] pc_next;

    // ========================================
    // next pc
    // ========================================
    assign pc_plus4_o = pc_o + `XLEN'd4;
    assign pc_target  = pc_o + imm_i;
    assign pc_next    = ctrl.pc_src ? pc_target : pc_plus4_o;

    // pc register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= `RESET_PC;
        end else begin
            pc_o <= pc_next;
        end
    end

    // targets are even by encoding, word alignment rests on offsets
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== risc_core.sv ====
`default_nettype none
`include "core_settings.svh"

module risc_core import core_pkg::*; (
    input  wire logic             clk,
    input  wire logic             arst_n_i,
    // fetch port
    output logic [`XLEN-1:0]      pc_o,
    input  wire logic [`XLEN-1:0] instr_i,
    // data memory port
    output logic [`XLEN-1:0]      dmem_addr_o,
    output logic [`XLEN-1:0]      dmem_wdata_o,
    output logic                  dmem_we_o,
    input  wire logic [`XLEN-1:0] dmem_rdata_i,
    // register write observation
    output logic                  rf_we_o,
    output logic [4:0]            rf_waddr_o,
    output logic [`XLEN-1:0]      rf_wdata_o
);

    // datapath nets
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    alu_flags_t       alu_flags;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] wb_data;

    // decoded control
    ctrl_if i_ctrl ();

    // ========================================
    // fetch and decode
    // ========================================
    pc_unit i_pc_unit (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .imm_i      (imm),
        .ctrl       (i_ctrl.datapath),
        .pc_o       (pc_o),
        .pc_plus4_o (pc_plus4)
    );

    control_decoder i_control_decoder (
        .instr_i (instr_i),
        .flags_i (alu_flags),
        .ctrl    (i_ctrl.decoder)
    );

    imm_extend i_imm_extend (
        .instr_i (instr_i),
        .ctrl    (i_ctrl.datapath),
        .imm_o   (imm)
    );

    // ========================================
    // execute
    // ========================================
    // rs1 rs2 rd at fixed positions
    register_file i_register_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rd_addr_i  (instr_i[11:7]),
        .rd_we_i    (i_ctrl.reg_write),
        .rd_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // operand b, immediate or rs2
    assign alu_b = i_ctrl.alu_src ? imm : rs2_data;

    alu i_alu (
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .op_i     (i_ctrl.alu_op),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    // ========================================
    // memory and writeback
    // ========================================
    // effective address is base + offset from the alu
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = i_ctrl.mem_write;

    always_comb begin
        case (i_ctrl.result_sel)
            RES_ALU: wb_data = alu_result;
            // load data used in the same cycle
            RES_MEM: wb_data = dmem_rdata_i;
            // jal link
            RES_PC4: wb_data = pc_plus4;
            // lui
            RES_IMM: wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

    // mirror of the register write port
    assign rf_we_o    = i_ctrl.reg_write;
    assign rf_waddr_o = instr_i[11:7];
    assign rf_wdata_o = wb_data;

endmodule

`default_nettype wire

// ==== tb_risc_core.sv ====
`default_nettype none
`include "core_settings.svh"

module tb_risc_core import core_pkg::*; ();

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic             clk;
    logic             arst_n_i;
    logic [`XLEN-1:0] pc_o;
    logic [`XLEN-1:0] instr_i;
    logic [`XLEN-1:0] dmem_addr_o;
    logic [`XLEN-1:0] dmem_wdata_o;
    logic             dmem_we_o;
    logic [`XLEN-1:0] dmem_rdata_i;
    logic             rf_we_o;
    logic [4:0]       rf_waddr_o;
    logic [`XLEN-1:0] rf_wdata_o;

    // bookkeeping
    int               errors;
    int               checks;
    int               tests;
    int               test_errors;
    string            cur_test;
    // pc of the instruction driven next
    logic [`XLEN-1:0] exp_pc;

    risc_core i_risc_core (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pc_o         (pc_o),
        .instr_i      (instr_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .rf_wdata_o   (rf_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // instruction encoders
    // ========================================
    function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] imm_instr(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw only, funct3 fixed
    function automatic logic [31:0] store_instr(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    // offset in bytes, bit 0 dropped
    function automatic logic [31:0] branch_instr(input logic [12:0] off, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_instr(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] lui_instr(input logic [19:0] up, input logic [4:0] rd);
        return {up, rd, OPC_LUI};
    endfunction

    // reference result of an alu instruction by funct3
    function automatic logic [31:0] op_result(input logic [2:0] f3, input bit sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 'x;
        endcase
    endfunction

    // kept alu funct3 values by index
    function automatic logic [2:0] pick_f3(input int idx);
        case (idx)
            0:       return 3'b000;
            1:       return 3'b111;
            2:       return 3'b110;
            3:       return 3'b100;
            default: return 3'b010;
        endcase
    endfunction

    // ========================================
    // check and drive helpers
    // ========================================
    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // one instruction per cycle, sampled mid-cycle
    task automatic run_instr(input logic [31:0] instr, input logic [31:0] rdata);
        @(posedge clk);
        instr_i      <= instr;
        dmem_rdata_i <= rdata;
        @(negedge clk);
        check_eq("pc_o", exp_pc, pc_o);
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic check_write(input logic [4:0] rd, input logic [31:0] value);
        check_eq("rf_we_o", 1, rf_we_o);
        check_eq("rf_waddr_o", rd, rf_waddr_o);
        check_eq("rf_wdata_o", value, rf_wdata_o);
        check_eq("dmem_we_o", 0, dmem_we_o);
    endtask

    // lui then addi, upper part rounded for the signed low half
    task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] up;
        up = value[31:12] + {19'd0, value[11]};
        run_instr(lui_instr(up, rd), 0);
        check_write(rd, {up, 12'h000});
        run_instr(imm_instr(value[11:0], rd, 3'b000, rd, OPC_OP_IMM), 0);
        check_write(rd, value);
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset_fetch(output bit ok);
        int cycles;
        int i;
        begin_test("reset_fetch");
        ok = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_eq("pc_o in reset", `RESET_PC, pc_o);
        @(posedge clk);
        arst_n_i <= 1'b1;
        // wait for release, bounded
        cycles = 0;
        while (!ok && cycles < 10) begin
            @(negedge clk);
            cycles++;
            if (arst_n_i === 1'b1 && pc_o === `RESET_PC) ok = 1'b1;
        end
        if (!ok) begin
            $display("timeout: pc_o did not settle at the reset address after reset release");
            errors++;
        end else begin
            // idle nop held through reset runs at the reset address
            exp_pc = `RESET_PC + 32'd4;
            for (i = 0; i < 4; i++) begin
                run_instr(NOP, 0);
                check_eq("dmem_we_o", 0, dmem_we_o);
            end
            // registers come out of reset cleared
            run_instr(r_instr(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 0);
            check_write(5'd3, 32'd0);
        end
        end_test();
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [2:0]  f3;
        bit          sub;
        int          i;
        begin_test("alu_ops");
        a = $urandom;
        b = $urandom;
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        // add sub and or xor slt
        for (i = 0; i < 6; i++) begin
            sub = (i == 1);
            f3  = (i == 0 || i == 1) ? 3'b000 : pick_f3(i - 1);
            run_instr(r_instr(sub ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3), 0);
            check_write(5'd3, op_result(f3, sub, a, b));
        end
        // immediate forms, second round with negative immediates
        for (i = 0; i < 10; i++) begin
            f3  = pick_f3(i % 5);
            imm = $urandom;
            if (i >= 5) imm[11] = 1'b1;
            run_instr(imm_instr(imm, 5'd1, f3, 5'd4, OPC_OP_IMM), 0);
            check_write(5'd4, op_result(f3, 0, a, {{20{imm[11]}}, imm}));
        end
        // signed compare corner: -5 against 3
        set_reg(5'd5, 32'hFFFF_FFFB);
        set_reg(5'd6, 32'd3);
        run_instr(r_instr(7'h00, 5'd6, 5'd5, 3'b010, 5'd7), 0);
        check_write(5'd7, 32'd1);
        run_instr(r_instr(7'h00, 5'd5, 5'd6, 3'b010, 5'd7), 0);
        check_write(5'd7, 32'd0);
        // slti -5 < -1
        run_instr(imm_instr(12'hFFF, 5'd5, 3'b010, 5'd7, OPC_OP_IMM), 0);
        check_write(5'd7, 32'd1);
        end_test();
    endtask

    task automatic test_lui_x0();
        logic [19:0] up;
        begin_test("lui_x0");
        up = $urandom;
        run_instr(lui_instr(up, 5'd8), 0);
        check_write(5'd8, {up, 12'h000});
        // writes aimed at x0 are dropped
        run_instr(imm_instr(12'h123, 5'd0, 3'b000, 5'd0, OPC_OP_IMM), 0);
        run_instr(lui_instr(up, 5'd0), 0);
        check_write(5'd0, {up, 12'h000});
        run_instr(r_instr(7'h00, 5'd0, 5'd0, 3'b000, 5'd5), 0);
        check_write(5'd5, 32'd0);
        end_test();
    endtask

    task automatic test_store_load();
        logic [31:0] base;
        logic [31:0] data;
        logic [31:0] word;
        logic [31:0] addr;
        logic [11:0] off;
        begin_test("store_load");
        base = $urandom;
        data = $urandom;
        word = $urandom;
        off  = $urandom;
        set_reg(5'd9, base);
        set_reg(5'd10, data);
        addr = base + {{20{off[11]}}, off};
        // sw x10, off(x9), read data ignored
        run_instr(store_instr(off, 5'd10, 5'd9), 32'hDEAD_BEEF);
        check_eq("dmem_we_o", 1, dmem_we_o);
        check_eq("dmem_addr_o", addr, dmem_addr_o);
        check_eq("dmem_wdata_o", data, dmem_wdata_o);
        check_eq("rf_we_o", 0, rf_we_o);
        // lw x11, off(x9)
        run_instr(imm_instr(off, 5'd9, 3'b010, 5'd11, OPC_LOAD), word);
        check_eq("dmem_addr_o", addr, dmem_addr_o);
        check_write(5'd11, word);
        // loaded word now sits in x11
        run_instr(r_instr(7'h00, 5'd0, 5'd11, 3'b000, 5'd12), 0);
        check_write(5'd12, word);
        end_test();
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input bit taken, input logic [12:0] off);
        logic [31:0] pc_now;
        pc_now = exp_pc;
        run_instr(branch_instr(off, rs2, rs1, f3), 0);
        check_eq("rf_we_o", 0, rf_we_o);
        check_eq("dmem_we_o", 0, dmem_we_o);
        if (taken) exp_pc = pc_now + {{19{off[12]}}, off};
        // following fetch shows the new pc
        run_instr(NOP, 0);
    endtask

    task automatic jal_case(input logic [4:0] rd, input logic [20:0] off);
        logic [31:0] pc_now;
        pc_now = exp_pc;
        run_instr(jal_instr(off, rd), 0);
        check_write(rd, pc_now + 32'd4);
        exp_pc = pc_now + {{11{off[20]}}, off};
        run_instr(NOP, 0);
    endtask

    task automatic test_branches();
        begin_test("branches");
        set_reg(5'd13, 32'd7);
        set_reg(5'd14, 32'd7);
        set_reg(5'd15, 32'hFFFF_FFFD);
        set_reg(5'd16, 32'd5);
        // beq
        branch_case(3'b000, 5'd13, 5'd14, 1, 13'd16);
        branch_case(3'b000, 5'd13, 5'd16, 0, 13'd16);
        // bne, backward offsets
        branch_case(3'b001, 5'd13, 5'd16, 1, -13'sd8);
        branch_case(3'b001, 5'd13, 5'd14, 0, -13'sd8);
        // blt, -3 < 5 signed
        branch_case(3'b100, 5'd15, 5'd16, 1, 13'd12);
        branch_case(3'b100, 5'd16, 5'd15, 0, 13'd12);
        jal_case(5'd17, 21'd40);
        jal_case(5'd18, -21'sd20);
        end_test();
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        bit reset_ok;
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        instr_i      = NOP;
        dmem_rdata_i = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        exp_pc       = `RESET_PC;
        void'($urandom(88797));
        test_reset_fetch(reset_ok);
        if (reset_ok) begin
            test_alu_ops();
            test_lui_x0();
            test_store_load();
            test_branches();
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
core_pkg.sv
ctrl_if.sv
control_decoder.sv
imm_extend.sv
alu.sv
register_file.sv
pc_unit.sv
risc_core.sv
tb_risc_core.sv
